// File: design/sad_geom_pkg.sv
package sad_geom_pkg;

    // --------------------
    // pixel format
    // --------------------

    // bits per pixel on both camera streams
    localparam int PIXEL_W = 8;

    // one camera sample
    typedef logic [PIXEL_W-1:0] pixel_t;

    // --------------------
    // matching window
    // --------------------

    // horizontal window length in pixels
    // taps run from pixel x back to x-CNTX_SIZE+1
    localparam int CNTX_SIZE = 3;

    // --------------------
    // cost format
    // --------------------

    // one clipped SAD value
    // same width as a pixel so the output bus packs evenly
    typedef logic [PIXEL_W-1:0] cost_t;

    // saturation value
    // also marks a window that reaches before the line start
    localparam cost_t COST_MAX = cost_t'(255);

endpackage

// File: design/sad_stream_pkg.sv
package sad_stream_pkg;

    // --------------------
    // beat layout
    // --------------------

    // pixels per beat on each camera
    localparam int LANES = 4;

    // input word width
    localparam int TDATA_W = LANES * sad_geom_pkg::PIXEL_W;

    // input word with two readings
    // raw is the bus as it arrives
    // pix[LANES-1] is the oldest pixel in x order, pix[0] the newest
    typedef union packed {
        logic [TDATA_W-1:0]                 raw;
        sad_geom_pkg::pixel_t [LANES-1:0]   pix;
    } sample_word_u;

    // --------------------
    // pipeline
    // --------------------

    // register stages inside each SAD lane
    // flags are delayed by the same count
    localparam int SAD_STAGES = 2;

endpackage

// File: design/sad_window_if.sv
`timescale 1ns/1ps

interface sad_window_if #(
    parameter int MAX_DISP = 8
);
    // pixel history lengths
    localparam int LEFT_N  = sad_stream_pkg::LANES + sad_geom_pkg::CNTX_SIZE - 1;
    localparam int RIGHT_N = sad_stream_pkg::LANES + MAX_DISP + sad_geom_pkg::CNTX_SIZE - 2;

    // index 0 is the newest pixel in both windows
    sad_geom_pkg::pixel_t [LEFT_N-1:0]  left_win;
    sad_geom_pkg::pixel_t [RIGHT_N-1:0] right_win;

    // one bit per right pixel, set when it lies in the current line
    logic [RIGHT_N-1:0] right_ok;

    // flags of the beat now held in the windows
    logic beat_valid;
    logic beat_last;
    logic beat_user;

    // global load enable from the output stage
    logic advance;

    modport builder (
        output left_win, right_win, right_ok,
        output beat_valid, beat_last, beat_user,
        input  advance
    );

    modport lane (
        input left_win, right_win, right_ok,
        input advance
    );

    modport drain (
        input  beat_valid, beat_last, beat_user,
        output advance
    );

endinterface

// File: design/disparity_window_builder.sv
`timescale 1ns/1ps

module disparity_window_builder #(
    parameter int MAX_DISP = 8
) (
    input  logic                         aclk,
    input  logic                         i_arst_n,

    // left camera
    input  sad_stream_pkg::sample_word_u i_l_tdata,
    input  logic                         i_l_tvalid,
    input  logic                         i_l_tlast,
    input  logic                         i_l_tuser,
    output logic                         o_l_tready,

    // right camera
    input  sad_stream_pkg::sample_word_u i_r_tdata,
    input  logic                         i_r_tvalid,
    input  logic                         i_r_tlast,
    input  logic                         i_r_tuser,
    output logic                         o_r_tready,

    // windows toward the lanes
    sad_window_if.builder                win
);

    localparam int LANES   = sad_stream_pkg::LANES;
    localparam int LEFT_N  = LANES + sad_geom_pkg::CNTX_SIZE - 1;
    localparam int RIGHT_N = LANES + MAX_DISP + sad_geom_pkg::CNTX_SIZE - 2;

    // beat taken from both cameras this cycle
    logic accept;

    // combined beat flags
    logic both_last;
    logic both_user;

    // next accepted beat opens a new line
    logic line_start;

    // --------------------
    // handshake
    // --------------------

    // each side waits for the other camera
    // so both streams move in lock step
    assign o_l_tready = win.advance & i_r_tvalid;
    assign o_r_tready = win.advance & i_l_tvalid;

    assign accept    = win.advance & i_l_tvalid & i_r_tvalid;
    assign both_last = i_l_tlast & i_r_tlast;
    assign both_user = i_l_tuser & i_r_tuser;

    // --------------------
    // pixel history
    // --------------------

    // new beat lands at the low end, older pixels move up
    // pix[0] is the newest so the pixel view drops straight in
    always_ff @(posedge aclk) begin
        if (accept) begin
            win.left_win[LANES-1:0]        <= i_l_tdata.pix;
            win.left_win[LEFT_N-1:LANES]   <= win.left_win[LEFT_N-LANES-1:0];
            win.right_win[LANES-1:0]       <= i_r_tdata.pix;
            win.right_win[RIGHT_N-1:LANES] <= win.right_win[RIGHT_N-LANES-1:0];
        end
    end

    // --------------------
    // line validity
    // --------------------

    // right pixels of the new beat are always in line
    // older ones are dropped at a line start
    always_ff @(posedge aclk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            win.right_ok <= '0;
            line_start   <= 1'b1;
        end else if (accept) begin
            win.right_ok[LANES-1:0] <= '1;
            if (line_start) begin
                win.right_ok[RIGHT_N-1:LANES] <= '0;
            end else begin
                win.right_ok[RIGHT_N-1:LANES] <= win.right_ok[RIGHT_N-LANES-1:0];
            end
            // a beat with last closes the line
            line_start <= both_last;
        end
    end

    // --------------------
    // beat flags
    // --------------------

    // a bubble moves when advance is high without a beat
    always_ff @(posedge aclk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            win.beat_valid <= 1'b0;
            win.beat_last  <= 1'b0;
            win.beat_user  <= 1'b0;
        end else if (win.advance) begin
            win.beat_valid <= accept;
            win.beat_last  <= accept & both_last;
            win.beat_user  <= accept & both_user;
        end
    end

endmodule

// File: design/sad_lane.sv
`timescale 1ns/1ps

module sad_lane #(
    parameter int MAX_DISP = 8,
    parameter int LANE     = 0
) (
    input  logic                                aclk,
    input  logic                                i_arst_n,
    sad_window_if.lane                          win,
    output sad_geom_pkg::cost_t [MAX_DISP-1:0]  o_costs
);

    localparam int CNTX  = sad_geom_pkg::CNTX_SIZE;
    localparam int PW    = sad_geom_pkg::PIXEL_W;
    // room for CNTX full scale differences
    localparam int SUM_W = PW + $clog2(CNTX);

    // stage one inputs and registers
    logic [MAX_DISP-1:0][CNTX-1:0][PW-1:0] diff_d;
    logic [MAX_DISP-1:0][CNTX-1:0][PW-1:0] diff_q;
    logic [MAX_DISP-1:0]                   bad_d;
    logic [MAX_DISP-1:0]                   bad_q;

    // stage two tap sums
    logic [MAX_DISP-1:0][SUM_W-1:0]        sum_d;

    // --------------------
    // stage one
    // --------------------

    // left tap t is pixel x-t, right tap is x-d-t
    // LANE offsets x inside the beat
    always_comb begin
        for (int d = 0; d < MAX_DISP; d++) begin
            bad_d[d] = 1'b0;
            for (int t = 0; t < CNTX; t++) begin
                if (win.left_win[LANE+t] > win.right_win[LANE+d+t]) begin
                    diff_d[d][t] = win.left_win[LANE+t] - win.right_win[LANE+d+t];
                end else begin
                    diff_d[d][t] = win.right_win[LANE+d+t] - win.left_win[LANE+t];
                end
                // any right tap outside the line spoils this disparity
                bad_d[d] = bad_d[d] | ~win.right_ok[LANE+d+t];
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (win.advance) begin
            diff_q <= diff_d;
        end
    end

    // nothing valid in flight after reset
    always_ff @(posedge aclk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            bad_q <= '1;
        end else if (win.advance) begin
            bad_q <= bad_d;
        end
    end

    // --------------------
    // stage two
    // --------------------

    always_comb begin
        for (int d = 0; d < MAX_DISP; d++) begin
            sum_d[d] = '0;
            for (int t = 0; t < CNTX; t++) begin
                sum_d[d] = sum_d[d] + SUM_W'(diff_q[d][t]);
            end
        end
    end

    // clip, then force invalid windows to the max
    always_ff @(posedge aclk) begin
        if (win.advance) begin
            for (int d = 0; d < MAX_DISP; d++) begin
                if (bad_q[d] || (sum_d[d] > SUM_W'(sad_geom_pkg::COST_MAX))) begin
                    o_costs[d] <= sad_geom_pkg::COST_MAX;
                end else begin
                    o_costs[d] <= sum_d[d][PW-1:0];
                end
            end
        end
    end

endmodule

// File: design/cost_output_stage.sv
`timescale 1ns/1ps

module cost_output_stage #(
    parameter int MAX_DISP = 8
) (
    input  logic                                   aclk,
    input  logic                                   i_arst_n,
    input  sad_geom_pkg::cost_t
           [sad_stream_pkg::LANES-1:0][MAX_DISP-1:0] i_lane_costs,
    input  logic                                   i_tready,
    sad_window_if.drain                            win,
    output logic [sad_stream_pkg::LANES*MAX_DISP*sad_geom_pkg::PIXEL_W-1:0] o_tdata,
    output logic                                   o_tvalid,
    output logic                                   o_tlast,
    output logic                                   o_tuser
);

    localparam int STAGES = sad_stream_pkg::SAD_STAGES;

    // flags travelling beside the lane pipeline
    logic [STAGES-1:0] valid_dly;
    logic [STAGES-1:0] last_dly;
    logic [STAGES-1:0] user_dly;

    // --------------------
    // stall control
    // --------------------

    // an empty output register can always take data
    assign win.advance = i_tready | ~o_tvalid;

    // --------------------
    // flag delay line
    // --------------------

    always_ff @(posedge aclk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            valid_dly <= '0;
            last_dly  <= '0;
            user_dly  <= '0;
            o_tvalid  <= 1'b0;
            o_tlast   <= 1'b0;
            o_tuser   <= 1'b0;
        end else if (win.advance) begin
            valid_dly[0] <= win.beat_valid;
            last_dly[0]  <= win.beat_last;
            user_dly[0]  <= win.beat_user;
            for (int i = 1; i < STAGES; i++) begin
                valid_dly[i] <= valid_dly[i-1];
                last_dly[i]  <= last_dly[i-1];
                user_dly[i]  <= user_dly[i-1];
            end
            // flags leave with the costs of their own beat
            o_tvalid <= valid_dly[STAGES-1];
            o_tlast  <= last_dly[STAGES-1];
            o_tuser  <= user_dly[STAGES-1];
        end
    end

    // --------------------
    // output register
    // --------------------

    // lane p in slice p, disparity d as cost d inside it
    always_ff @(posedge aclk) begin
        if (win.advance) begin
            o_tdata <= i_lane_costs;
        end
    end

endmodule

// File: design/stereo_sad_top.sv
`timescale 1ns/1ps

module stereo_sad_top #(
    parameter int MAX_DISP = 8
) (
    input  logic                                 aclk,
    input  logic                                 i_arst_n,

    // left camera stream
    input  logic [sad_stream_pkg::TDATA_W-1:0]   i_l_tdata,
    input  logic                                 i_l_tvalid,
    input  logic                                 i_l_tlast,
    input  logic                                 i_l_tuser,
    output logic                                 o_l_tready,

    // right camera stream
    input  logic [sad_stream_pkg::TDATA_W-1:0]   i_r_tdata,
    input  logic                                 i_r_tvalid,
    input  logic                                 i_r_tlast,
    input  logic                                 i_r_tuser,
    output logic                                 o_r_tready,

    // cost stream
    input  logic                                 i_tready,
    output logic [sad_stream_pkg::LANES*MAX_DISP*sad_geom_pkg::PIXEL_W-1:0] o_tdata,
    output logic                                 o_tvalid,
    output logic                                 o_tlast,
    output logic                                 o_tuser
);

    // incoming buses seen through the union
    sad_stream_pkg::sample_word_u l_word;
    sad_stream_pkg::sample_word_u r_word;

    // per lane cost vectors
    sad_geom_pkg::cost_t [sad_stream_pkg::LANES-1:0][MAX_DISP-1:0] lane_costs;

    assign l_word.raw = i_l_tdata;
    assign r_word.raw = i_r_tdata;

    sad_window_if #(.MAX_DISP(MAX_DISP)) win ();

    // --------------------
    // window builder
    // --------------------

    disparity_window_builder #(
        .MAX_DISP   (MAX_DISP)
    ) u_builder (
        .aclk       (aclk),
        .i_arst_n   (i_arst_n),
        .i_l_tdata  (l_word),
        .i_l_tvalid (i_l_tvalid),
        .i_l_tlast  (i_l_tlast),
        .i_l_tuser  (i_l_tuser),
        .o_l_tready (o_l_tready),
        .i_r_tdata  (r_word),
        .i_r_tvalid (i_r_tvalid),
        .i_r_tlast  (i_r_tlast),
        .i_r_tuser  (i_r_tuser),
        .o_r_tready (o_r_tready),
        .win        (win.builder)
    );

    // --------------------
    // SAD lanes
    // --------------------

    // one lane per pixel position in the beat
    for (genvar p = 0; p < sad_stream_pkg::LANES; p++) begin : g_lane
        sad_lane #(
            .MAX_DISP (MAX_DISP),
            .LANE     (p)
        ) u_lane (
            .aclk     (aclk),
            .i_arst_n (i_arst_n),
            .win      (win.lane),
            .o_costs  (lane_costs[p])
        );
    end

    // --------------------
    // output stage
    // --------------------

    cost_output_stage #(
        .MAX_DISP     (MAX_DISP)
    ) u_out (
        .aclk         (aclk),
        .i_arst_n     (i_arst_n),
        .i_lane_costs (lane_costs),
        .i_tready     (i_tready),
        .win          (win.drain),
        .o_tdata      (o_tdata),
        .o_tvalid     (o_tvalid),
        .o_tlast      (o_tlast),
        .o_tuser      (o_tuser)
    );

endmodule

// File: sim/sad_checker.sv
`timescale 1ns/1ps

module sad_checker #(
    parameter int MAX_DISP = 8,
    parameter int DATA_W   = sad_stream_pkg::LANES * MAX_DISP * sad_geom_pkg::PIXEL_W
) (
    // DUT ports under their own names
    input  logic              aclk,
    input  logic [31:0]       i_l_tdata,
    input  logic [31:0]       i_r_tdata,
    input  logic              i_l_tvalid,
    input  logic              i_r_tvalid,
    input  logic              i_l_tlast,
    input  logic              i_r_tlast,
    input  logic              i_l_tuser,
    input  logic              i_r_tuser,
    input  logic              o_l_tready,
    input  logic              i_tready,
    input  logic [DATA_W-1:0] o_tdata,
    input  logic              o_tvalid,
    input  logic              o_tlast,
    input  logic              o_tuser,
    // test context from the stimulus loop
    input  logic [127:0]      i_test_name,
    input  logic [8:0]        i_spot_exp,
    output int                o_mismatches,
    output int                o_other_errors,
    output int                o_checked,
    output int                o_pending
);

    localparam int CNTX  = sad_geom_pkg::CNTX_SIZE;
    localparam int LANES = sad_stream_pkg::LANES;
    localparam int MAXC  = 255;

    // pixels of the current line in x order
    int l_line[$];
    int r_line[$];

    // expected beats, oldest first
    logic [DATA_W-1:0] exp_data[$];
    logic [1:0]        exp_flags[$];
    logic [127:0]      exp_name[$];
    logic [8:0]        exp_spot[$];

    // left x..x-2 against right x-d..x-d-2, saturating
    function automatic int window_cost(input int x, input int d);
        int sum;
        int a;
        int b;
        sum = 0;
        // right tap before the line start
        if (x - d - (CNTX - 1) < 0) begin
            return MAXC;
        end
        for (int t = 0; t < CNTX; t++) begin
            a = l_line[x-t];
            b = r_line[x-d-t];
            sum += (a > b) ? a - b : b - a;
        end
        return (sum > MAXC) ? MAXC : sum;
    endfunction

    initial begin
        o_mismatches   = 0;
        o_other_errors = 0;
        o_checked      = 0;
        o_pending      = 0;
    end

    // sampled mid cycle, the transfer itself happens at the next rising edge
    always @(negedge aclk) begin : compare
        logic [DATA_W-1:0] word;
        // output side
        if (o_tvalid && i_tready) begin
            if (exp_data.size() == 0) begin
                $display("ERROR: output beat appeared with no accepted input beat behind it");
                o_other_errors++;
            end else begin
                if (o_tdata !== exp_data[0]) begin
                    $display("Mismatch %0s costs: expected %h actual %h",
                             exp_name[0], exp_data[0], o_tdata);
                    o_mismatches++;
                end
                if ({o_tlast, o_tuser} !== exp_flags[0]) begin
                    $display("Mismatch %0s last/user: expected %b actual %b",
                             exp_name[0], exp_flags[0], {o_tlast, o_tuser});
                    o_mismatches++;
                end
                // table spot value for lane 0, disparity 0
                if (exp_spot[0][8] && (o_tdata[7:0] !== exp_spot[0][7:0])) begin
                    $display("Mismatch %0s lane0 disp0: expected %0d actual %0d",
                             exp_name[0], exp_spot[0][7:0], o_tdata[7:0]);
                    o_mismatches++;
                end
                void'(exp_data.pop_front());
                void'(exp_flags.pop_front());
                void'(exp_name.pop_front());
                void'(exp_spot.pop_front());
                o_checked++;
            end
        end
        // input side, top byte is the oldest pixel
        if (i_l_tvalid && i_r_tvalid && o_l_tready) begin
            for (int k = LANES - 1; k >= 0; k--) begin
                l_line.push_back(i_l_tdata[8*k +: 8]);
                r_line.push_back(i_r_tdata[8*k +: 8]);
            end
            // lane p is the p-th newest pixel of the beat
            for (int p = 0; p < LANES; p++) begin
                for (int d = 0; d < MAX_DISP; d++) begin
                    word[(p*MAX_DISP+d)*8 +: 8] = 8'(window_cost(l_line.size() - 1 - p, d));
                end
            end
            exp_data.push_back(word);
            exp_flags.push_back({i_l_tlast & i_r_tlast, i_l_tuser & i_r_tuser});
            exp_name.push_back(i_test_name);
            exp_spot.push_back(i_spot_exp);
            // next beat opens a new line
            if (i_l_tlast && i_r_tlast) begin
                l_line.delete();
                r_line.delete();
            end
        end
        o_pending = exp_data.size();
    end

endmodule

// File: sim/stereo_sad_sva.sv
`timescale 1ns/1ps

module stereo_sad_sva #(
    parameter int MAX_DISP = 8
) (
    input logic aclk,
    input logic i_arst_n,
    input logic i_l_tvalid,
    input logic i_r_tvalid,
    input logic o_l_tready,
    input logic o_r_tready,
    input logic i_tready,
    input logic [sad_stream_pkg::LANES*MAX_DISP*sad_geom_pkg::PIXEL_W-1:0] o_tdata,
    input logic o_tvalid,
    input logic o_tlast,
    input logic o_tuser
);

    // assertion failures so far
    int fail_count = 0;

    // output register empty while reset is held
    a_reset_idle: assert property (@(posedge aclk) !i_arst_n |-> !o_tvalid)
        else begin
            $error("o_tvalid high while reset is asserted");
            fail_count++;
        end

    // stalled beat keeps its data and flags
    a_stall_hold: assert property (@(posedge aclk) disable iff (!i_arst_n)
        (o_tvalid && !i_tready) |=>
        (o_tvalid && $stable(o_tdata) && $stable(o_tlast) && $stable(o_tuser)))
        else begin
            $error("output beat changed while stalled");
            fail_count++;
        end

    // cameras move in lock step
    a_ready_pair: assert property (@(posedge aclk) disable iff (!i_arst_n)
        (i_l_tvalid && i_r_tvalid) |-> (o_l_tready == o_r_tready))
        else begin
            $error("left and right readies differ with both tvalids high");
            fail_count++;
        end

endmodule

bind stereo_sad_top stereo_sad_sva #(.MAX_DISP(MAX_DISP)) u_sva (.*);

// File: sim/tb_stereo_sad.sv
`timescale 1ns/1ps

module tb_stereo_sad;

    localparam int MAX_DISP   = 8;
    localparam int CLK_PERIOD = 20;
    localparam int RST_CYCLES = 16;
    localparam int N_TESTS    = 20;
    localparam int MAX_HOLD   = 6;
    localparam int DATA_W     = sad_stream_pkg::LANES * MAX_DISP * sad_geom_pkg::PIXEL_W;

    // DUT ports, same names for .* hookup
    logic              aclk;
    logic              i_arst_n;
    logic [31:0]       i_l_tdata;
    logic [31:0]       i_r_tdata;
    logic              i_l_tvalid, i_l_tlast, i_l_tuser, o_l_tready;
    logic              i_r_tvalid, i_r_tlast, i_r_tuser, o_r_tready;
    logic              i_tready;
    logic [DATA_W-1:0] o_tdata;
    logic              o_tvalid, o_tlast, o_tuser;

    // --------------------
    // stimulus table
    // --------------------
    logic [127:0] t_name[N_TESTS];
    logic [31:0]  t_left[N_TESTS];
    logic [31:0]  t_right[N_TESTS];
    logic         t_last[N_TESTS];
    logic         t_user[N_TESTS];
    int           t_hold[N_TESTS];
    logic [8:0]   t_spot[N_TESTS];

    int           n_entries;
    int           seed;
    logic [127:0] cur_name;
    logic [8:0]   cur_spot;
    int           mismatches, chk_other, checked, pending;

    stereo_sad_top #(.MAX_DISP(MAX_DISP)) uut (.*);

    sad_checker #(.MAX_DISP(MAX_DISP)) u_checker (
        .*,
        .i_test_name    (cur_name),
        .i_spot_exp     (cur_spot),
        .o_mismatches   (mismatches),
        .o_other_errors (chk_other),
        .o_checked      (checked),
        .o_pending      (pending)
    );

    always #(CLK_PERIOD / 2) aclk = ~aclk;

    // spot of -1 means no lane 0 spot value
    task automatic add_entry(input logic [127:0] name, input logic [31:0] lw,
                             input logic [31:0] rw, input logic last, input logic user,
                             input int hold, input int spot);
        t_name[n_entries]  = name;
        t_left[n_entries]  = lw;
        t_right[n_entries] = rw;
        t_last[n_entries]  = last;
        t_user[n_entries]  = user;
        t_hold[n_entries]  = hold;
        t_spot[n_entries]  = (spot < 0) ? 9'h0 : {1'b1, 8'(spot)};
        n_entries++;
    endtask

    // ramp line pixel x is 9x+3, oldest pixel in the top byte
    function automatic logic [31:0] ramp_word(input int x0);
        logic [31:0] w;
        for (int k = 0; k < 4; k++) begin
            w[8*(3-k) +: 8] = 8'((x0 + k) * 9 + 3);
        end
        return w;
    endfunction

    task automatic build_table;
        logic [31:0] lw;
        logic [31:0] rw;
        // identical lines
        add_entry("ident_a", 32'h10203040, 32'h10203040, 1'b0, 1'b1, 0, 0);
        add_entry("ident_b", 32'h50607080, 32'h50607080, 1'b0, 1'b0, 0, 0);
        add_entry("ident_c", 32'h90a0b0c0, 32'h90a0b0c0, 1'b1, 1'b0, 0, 0);
        // right line runs 3 pixels ahead, disparity 3 matches
        for (int b = 0; b < 4; b++) begin
            add_entry("shift3", ramp_word(4 * b), ramp_word(4 * b + 3), b == 3, 1'b0, 0, 81);
        end
        // sums past the clip level
        add_entry("saturate_a", 32'hffffffff, 32'h00000000, 1'b0, 1'b0, 0, 255);
        add_entry("saturate_b", 32'h00000000, 32'hffffffff, 1'b1, 1'b0, 0, 255);
        // one beat line with both flags
        add_entry("last_user", 32'h01020304, 32'h01020305, 1'b1, 1'b1, 0, 1);
        // random pixels under output stalls
        for (int b = 0; b < 4; b++) begin
            lw = $random(seed);
            rw = $random(seed);
            add_entry("stall_rand", lw, rw, b == 3, 1'b0,
                      (b == 0) ? 5 : (b == 2) ? MAX_HOLD : (b == 3) ? 3 : 0, -1);
        end
        // random line, right within 15 of left at disparity 0
        for (int b = 0; b < 6; b++) begin
            lw = $random(seed);
            rw = lw ^ ($random(seed) & 32'h0f0f0f0f);
            add_entry("rand_line", lw, rw, b == 5, b == 0, 0, -1);
        end
    endtask

    // present one beat, stall the output for its hold count, wait for accept
    task automatic apply_entry(input int k);
        int   held;
        logic take;
        held       = 0;
        take       = 1'b0;
        i_l_tdata  = t_left[k];
        i_r_tdata  = t_right[k];
        i_l_tvalid = 1'b1;
        i_r_tvalid = 1'b1;
        i_l_tlast  = t_last[k];
        i_r_tlast  = t_last[k];
        i_l_tuser  = t_user[k];
        i_r_tuser  = t_user[k];
        cur_name   = t_name[k];
        cur_spot   = t_spot[k];
        i_tready   = (t_hold[k] == 0);
        while (!take) begin
            @(negedge aclk);
            take = i_l_tvalid & i_r_tvalid & o_l_tready;
            @(posedge aclk);
            #2;
            held++;
            if (held >= t_hold[k]) begin
                i_tready = 1'b1;
            end
        end
    endtask

    initial begin
        aclk         = 1'b0;
        i_arst_n     = 1'b0;
        i_l_tdata    = '0;
        i_r_tdata    = '0;
        i_l_tvalid   = 1'b0;
        i_r_tvalid   = 1'b0;
        i_l_tlast    = 1'b0;
        i_r_tlast    = 1'b0;
        i_l_tuser    = 1'b0;
        i_r_tuser    = 1'b0;
        i_tready     = 1'b1;
        cur_name     = "reset";
        cur_spot     = 9'h0;
        seed         = 32'h78;
        n_entries    = 0;
        build_table();
        repeat (RST_CYCLES) @(posedge aclk);
        #2;
        i_arst_n = 1'b1;
        @(posedge aclk);
        #2;
        for (int k = 0; k < n_entries; k++) begin
            apply_entry(k);
        end
        i_l_tvalid = 1'b0;
        i_r_tvalid = 1'b0;
        i_tready   = 1'b1;
        // drain, then a few idle cycles to catch stray beats
        while (pending != 0) @(posedge aclk);
        repeat (4) @(posedge aclk);
        $display("errors: %0d mismatches, %0d other, %0d assertion, %0d beats checked",
                 mismatches, chk_other, uut.u_sva.fail_count, checked);
        if (mismatches == 0 && chk_other == 0 && uut.u_sva.fail_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // reset, every entry at its longest hold, plus drain margin
    initial begin
        #((RST_CYCLES + N_TESTS * (1 + MAX_HOLD) + 20) * CLK_PERIOD);
        $display("ERROR: timeout, the run did not finish in the expected time");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: flist.f
design/sad_geom_pkg.sv
design/sad_stream_pkg.sv
design/sad_window_if.sv
design/disparity_window_builder.sv
design/sad_lane.sv
design/cost_output_stage.sv
design/stereo_sad_top.sv
sim/sad_checker.sv
sim/stereo_sad_sva.sv
sim/tb_stereo_sad.sv
